/* include/region_merge_params.svh */
// region count, stream data width, tid width and header length width
`ifndef REGION_MERGE_PARAMS_SVH
`define REGION_MERGE_PARAMS_SVH

`define RM_N_REGIONS 4   // number of user regions behind the arbiter
`define RM_DATA_BITS 32  // stream word width, also the header word width
`define RM_ID_BITS   2   // tid width, one id per region
`define RM_LEN_BITS  8   // payload length field in the header beat

`endif

/* source/stream_pkg.sv */
// beat types: header struct, header-or-data union and beat kind enum
`default_nettype none

`include "region_merge_params.svh"

package stream_pkg;

  // the first beat of every packet is read as this header
  // len sits in the upper bits and the tag fills the rest of the word
  typedef struct packed {
    logic [`RM_LEN_BITS-1:0]              len;  // number of payload beats that follow
    logic [`RM_DATA_BITS-`RM_LEN_BITS-1:0] tag;  // opaque label copied into the report
  } hdr_t;

  // one stream word, decoded as hdr on the first beat and as data on every later beat
  typedef union packed {
    hdr_t                    hdr;
    logic [`RM_DATA_BITS-1:0] data;
  } beat_u;

  // classification made by the decode stage
  typedef enum logic {
    KIND_HDR     = 1'b0,
    KIND_PAYLOAD = 1'b1
  } beat_kind_e;

endpackage

`default_nettype wire

/* source/report_pkg.sv */
// packet result types: report struct and per-tid accumulator struct
`default_nettype none

`include "region_merge_params.svh"

package report_pkg;

  typedef struct packed {
    logic [`RM_ID_BITS-1:0]                tid;
    logic [`RM_DATA_BITS-`RM_LEN_BITS-1:0] tag;
    logic [`RM_LEN_BITS-1:0]               count;    // payload beats actually seen
    logic                                  len_err;  // count did not match header len
    logic [`RM_DATA_BITS-1:0]              sum;      // wrapping sum of payload words
  } pkt_report_t;

  // running state kept by execute for one tid while its packet is open
  typedef struct packed {
    logic [`RM_LEN_BITS-1:0]               len;
    logic [`RM_DATA_BITS-`RM_LEN_BITS-1:0] tag;
    logic [`RM_LEN_BITS-1:0]               count;
    logic [`RM_DATA_BITS-1:0]              sum;
  } acc_t;

endpackage

`default_nettype wire

/* source/beat_if.sv */
// beat_if interface: one pipelined beat with its decoded kind and an optional report
`timescale 1ns/10ps
`default_nettype none

`include "region_merge_params.svh"

interface beat_if
  import stream_pkg::*, report_pkg::*;
();

  logic                       valid;
  logic                       ready;
  beat_u                      word;       // raw word, view chosen by kind
  logic [`RM_DATA_BITS/8-1:0] keep;
  logic                       last;
  logic [`RM_ID_BITS-1:0]     tid;
  beat_kind_e                 kind;
  pkt_report_t                report;     // only meaningful together with report_en
  logic                       report_en;  // set on the last beat of a packet

  modport src (output valid, word, keep, last, tid, kind, report, report_en, input ready);
  modport snk (input valid, word, keep, last, tid, kind, report, report_en, output ready);

endinterface

`default_nettype wire

/* source/rr_arbiter.sv */
// rr_arbiter module: round-robin merge of the region streams into one stream
`timescale 1ns/10ps
`default_nettype none

`include "region_merge_params.svh"

module rr_arbiter #(
  parameter int N_REGIONS = `RM_N_REGIONS,
  parameter int DATA_BITS = `RM_DATA_BITS,
  parameter int ID_BITS   = `RM_ID_BITS
) (
  input  wire logic                                 aclk,
  input  wire logic                                 aresetn,
  input  wire logic [N_REGIONS-1:0]                 s_tvalid,
  output      logic [N_REGIONS-1:0]                 s_tready,
  input  wire logic [N_REGIONS-1:0][DATA_BITS-1:0]   s_tdata,
  input  wire logic [N_REGIONS-1:0][DATA_BITS/8-1:0] s_tkeep,
  input  wire logic [N_REGIONS-1:0]                 s_tlast,
  input  wire logic [N_REGIONS-1:0][ID_BITS-1:0]     s_tid,
  output      logic                                 m_tvalid,
  input  wire logic                                 m_tready,
  output      logic [DATA_BITS-1:0]                 m_tdata,
  output      logic [DATA_BITS/8-1:0]               m_tkeep,
  output      logic                                 m_tlast,
  output      logic [ID_BITS-1:0]                   m_tid
);

  localparam int PTR_BITS = (N_REGIONS > 1) ? $clog2(N_REGIONS) : 1;

  logic [PTR_BITS-1:0] ptr;  // region with the highest priority this cycle
  logic [PTR_BITS-1:0] sel;  // granted region

  // ------------------------------
  // rotating priority pointer
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ptr <= '0;
    end else if (m_tvalid && m_tready) begin
      // moves on every accepted beat, so packets from different regions interleave
      ptr <= (ptr == PTR_BITS'(N_REGIONS - 1)) ? '0 : ptr + 1'b1;
    end
  end

  // search upward from ptr with wrap and let the first valid region win
  always_comb begin
    int unsigned idx;
    logic        found;
    found    = 1'b0;
    sel      = ptr;
    for (int i = 0; i < N_REGIONS; i++) begin
      idx = int'(ptr) + i;
      if (idx >= N_REGIONS) idx = idx - N_REGIONS;
      if (!found && s_tvalid[idx]) begin
        found = 1'b1;
        sel   = PTR_BITS'(idx);
      end
    end
    m_tvalid      = found;
    s_tready      = '0;
    s_tready[sel] = found && m_tready;  // only a granted region sees the downstream ready
    m_tdata       = s_tdata[sel];
    m_tkeep       = s_tkeep[sel];
    m_tlast       = s_tlast[sel];
    m_tid         = s_tid[sel];
  end

  // ready only ever goes to a region that is offering a beat
  a_ready_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    (s_tready & ~s_tvalid) == '0);

  // the region at the pointer wins whenever it is valid
  a_ptr_first: assert property (@(posedge aclk) disable iff (!aresetn)
    s_tvalid[ptr] |-> sel == ptr);

endmodule

`default_nettype wire

/* source/pkt_decode.sv */
// pkt_decode module: per-tid packet start tracking and header or payload classification
`timescale 1ns/10ps
`default_nettype none

`include "region_merge_params.svh"

module pkt_decode
  import stream_pkg::*;
(
  input  wire logic                       aclk,
  input  wire logic                       aresetn,
  input  wire logic                       in_valid,
  output      logic                       in_ready,
  input  wire logic [`RM_DATA_BITS-1:0]   in_data,
  input  wire logic [`RM_DATA_BITS/8-1:0] in_keep,
  input  wire logic                       in_last,
  input  wire logic [`RM_ID_BITS-1:0]     in_tid,
  beat_if.src                             out
);

  localparam int N_IDS = 2 ** `RM_ID_BITS;

  logic [N_IDS-1:0] in_pkt;  // one bit per tid, set between header and last beat
  logic             xfer;

  assign in_ready = !out.valid || out.ready;  // empty or draining this cycle
  assign xfer     = in_valid && in_ready;

  // ------------------------------
  // control state
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out.valid <= 1'b0;
      in_pkt    <= '0;
    end else begin
      if (in_ready) out.valid <= in_valid;
      // a last beat closes the packet, anything else leaves it open
      if (xfer) in_pkt[in_tid] <= !in_last;
    end
  end

  // beat register, only loaded on a transfer so it holds under back-pressure
  always_ff @(posedge aclk) begin
    if (xfer) begin
      out.word.data <= in_data;
      out.keep      <= in_keep;
      out.last      <= in_last;
      out.tid       <= in_tid;
      out.kind      <= in_pkt[in_tid] ? KIND_PAYLOAD : KIND_HDR;
    end
  end

  // reports are formed further down the pipeline
  assign out.report    = '0;
  assign out.report_en = 1'b0;

  a_hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    out.valid && !out.ready |=> out.valid && $stable(out.word));

endmodule

`default_nettype wire

/* source/pkt_execute.sv */
// pkt_execute module: per-tid beat count and payload sum with length check at tlast
`timescale 1ns/10ps
`default_nettype none

`include "region_merge_params.svh"

module pkt_execute
  import stream_pkg::*, report_pkg::*;
(
  input  wire logic aclk,
  input  wire logic aresetn,
  beat_if.snk       in,
  beat_if.src       out
);

  localparam int N_IDS = 2 ** `RM_ID_BITS;

  acc_t             acc [N_IDS];  // running state per tid
  acc_t             cur_acc;
  acc_t             nxt_acc;
  pkt_report_t      report_d;
  logic [N_IDS-1:0] open_pkt;     // tid has seen a header and no last yet
  logic             xfer;
  logic             is_hdr;

  assign in.ready = !out.valid || out.ready;
  assign xfer     = in.valid && in.ready;
  assign is_hdr   = (in.kind == KIND_HDR);
  assign cur_acc  = acc[in.tid];

  // ------------------------------
  // accumulator update
  // ------------------------------
  always_comb begin
    if (is_hdr) begin
      nxt_acc.len   = in.word.hdr.len;  // header view of the word
      nxt_acc.tag   = in.word.hdr.tag;
      nxt_acc.count = '0;               // a header alone gives an empty packet
      nxt_acc.sum   = '0;
    end else begin
      nxt_acc       = cur_acc;
      nxt_acc.count = cur_acc.count + 1'b1;
      nxt_acc.sum   = cur_acc.sum + in.word.data;  // data view, wraps at 32 bits
    end
    report_d.tid     = in.tid;
    report_d.tag     = nxt_acc.tag;
    report_d.count   = nxt_acc.count;
    report_d.len_err = (nxt_acc.count != nxt_acc.len);
    report_d.sum     = nxt_acc.sum;
  end

  always_ff @(posedge aclk) begin
    if (xfer) acc[in.tid] <= nxt_acc;
  end

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out.valid <= 1'b0;
      open_pkt  <= '0;
    end else begin
      if (in.ready) out.valid <= in.valid;
      if (xfer) open_pkt[in.tid] <= !in.last;
    end
  end

  always_ff @(posedge aclk) begin
    if (xfer) begin
      out.word      <= in.word;
      out.keep      <= in.keep;
      out.last      <= in.last;
      out.tid       <= in.tid;
      out.kind      <= in.kind;
      out.report    <= report_d;
      out.report_en <= in.last;  // report rides on the closing beat
    end
  end

  // decode must never open a packet twice for the same tid
  a_no_double_hdr: assert property (@(posedge aclk) disable iff (!aresetn)
    xfer && is_hdr |-> !open_pkt[in.tid]);

endmodule

`default_nettype wire

/* source/pkt_result.sv */
// pkt_result module: output register slice and one-shot packet report strobe
`timescale 1ns/10ps
`default_nettype none

`include "region_merge_params.svh"

module pkt_result
  import report_pkg::*;
(
  input  wire logic                       aclk,
  input  wire logic                       aresetn,
  beat_if.snk                             in,
  output      logic                       m_tvalid,
  input  wire logic                       m_tready,
  output      logic [`RM_DATA_BITS-1:0]   m_tdata,
  output      logic [`RM_DATA_BITS/8-1:0] m_tkeep,
  output      logic                       m_tlast,
  output      logic [`RM_ID_BITS-1:0]     m_tid,
  output      logic                       rpt_valid,
  output      pkt_report_t                rpt
);

  logic load;

  assign in.ready = !m_tvalid || m_tready;
  assign load     = in.valid && in.ready;

  // ------------------------------
  // strobes
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_tvalid  <= 1'b0;
      rpt_valid <= 1'b0;
    end else begin
      if (in.ready) m_tvalid <= in.valid;
      // high only in the cycle the last beat is loaded, a stall does not repeat it
      rpt_valid <= load && in.report_en;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      m_tdata <= in.word.data;
      m_tkeep <= in.keep;
      m_tlast <= in.last;
      m_tid   <= in.tid;
    end
    if (load && in.report_en) rpt <= in.report;  // kept until the next packet ends
  end

  a_rpt_on_last: assert property (@(posedge aclk) disable iff (!aresetn)
    rpt_valid |-> m_tvalid && m_tlast);

endmodule

`default_nettype wire

/* source/region_merge_top.sv */
// region_merge_top module: arbiter and decode, execute, result stages behind plain ports
`timescale 1ns/10ps
`default_nettype none

`include "region_merge_params.svh"

module region_merge_top
  import report_pkg::*;
(
  input  wire logic                                          aclk,
  input  wire logic                                          aresetn,
  input  wire logic [`RM_N_REGIONS-1:0]                      s_tvalid,
  output      logic [`RM_N_REGIONS-1:0]                      s_tready,
  input  wire logic [`RM_N_REGIONS-1:0][`RM_DATA_BITS-1:0]   s_tdata,
  input  wire logic [`RM_N_REGIONS-1:0][`RM_DATA_BITS/8-1:0] s_tkeep,
  input  wire logic [`RM_N_REGIONS-1:0]                      s_tlast,
  input  wire logic [`RM_N_REGIONS-1:0][`RM_ID_BITS-1:0]     s_tid,
  output      logic                                          m_tvalid,
  input  wire logic                                          m_tready,
  output      logic [`RM_DATA_BITS-1:0]                      m_tdata,
  output      logic [`RM_DATA_BITS/8-1:0]                    m_tkeep,
  output      logic                                          m_tlast,
  output      logic [`RM_ID_BITS-1:0]                        m_tid,
  output      logic                                          rpt_valid,
  output      logic [`RM_ID_BITS-1:0]                        rpt_tid,
  output      logic [`RM_DATA_BITS-`RM_LEN_BITS-1:0]         rpt_tag,
  output      logic [`RM_LEN_BITS-1:0]                       rpt_count,
  output      logic                                          rpt_len_err,
  output      logic [`RM_DATA_BITS-1:0]                      rpt_sum
);

  // merged stream between arbiter and decode
  logic                       arb_valid;
  logic                       arb_ready;
  logic [`RM_DATA_BITS-1:0]   arb_data;
  logic [`RM_DATA_BITS/8-1:0] arb_keep;
  logic                       arb_last;
  logic [`RM_ID_BITS-1:0]     arb_tid;
  pkt_report_t                rpt;

  beat_if dec_to_exe ();
  beat_if exe_to_res ();

  rr_arbiter u_arb (
    .aclk, .aresetn,
    .s_tvalid, .s_tready, .s_tdata, .s_tkeep, .s_tlast, .s_tid,
    .m_tvalid (arb_valid), .m_tready (arb_ready), .m_tdata (arb_data),
    .m_tkeep  (arb_keep),  .m_tlast  (arb_last),  .m_tid   (arb_tid)
  );

  pkt_decode u_dec (
    .aclk, .aresetn,
    .in_valid (arb_valid), .in_ready (arb_ready), .in_data (arb_data),
    .in_keep  (arb_keep),  .in_last  (arb_last),  .in_tid  (arb_tid),
    .out      (dec_to_exe)
  );

  pkt_execute u_exe (.aclk, .aresetn, .in (dec_to_exe), .out (exe_to_res));

  pkt_result u_res (
    .aclk, .aresetn, .in (exe_to_res),
    .m_tvalid, .m_tready, .m_tdata, .m_tkeep, .m_tlast, .m_tid,
    .rpt_valid, .rpt
  );

  // report struct flattened onto plain ports
  assign rpt_tid     = rpt.tid;
  assign rpt_tag     = rpt.tag;
  assign rpt_count   = rpt.count;
  assign rpt_len_err = rpt.len_err;
  assign rpt_sum     = rpt.sum;

endmodule

`default_nettype wire

/* bench/region_merge_tb.sv */
// region_merge_tb module: random region packets, per-tid reference model, compare tasks, timeout
`timescale 1ns/10ps
`default_nettype none

`include "region_merge_params.svh"

module region_merge_tb
  import stream_pkg::*, report_pkg::*;
();

  localparam int N_REG     = `RM_N_REGIONS;
  localparam int N_IDS     = 1 << `RM_ID_BITS;
  localparam int ID_BITS   = `RM_ID_BITS;
  localparam int LEN_BITS  = `RM_LEN_BITS;
  localparam int TAG_BITS  = `RM_DATA_BITS - `RM_LEN_BITS;
  localparam int KEEP_BITS = `RM_DATA_BITS / 8;
  localparam int PKTS      = 16;  // packets per region
  localparam int MAX_LEN   = 5;   // header len is drawn from 0 to this

  // one beat as a region offers it and as it must come out again
  typedef struct packed {
    beat_u                word;
    logic [KEEP_BITS-1:0] keep;
    logic                 last;
    logic [ID_BITS-1:0]   tid;
  } tb_beat_t;

  logic                                      aclk;
  logic                                      aresetn;
  logic [N_REG-1:0]                          s_tvalid;
  logic [N_REG-1:0]                          s_tready;
  logic [N_REG-1:0][`RM_DATA_BITS-1:0]       s_tdata;
  logic [N_REG-1:0][KEEP_BITS-1:0]           s_tkeep;
  logic [N_REG-1:0]                          s_tlast;
  logic [N_REG-1:0][ID_BITS-1:0]             s_tid;
  logic                                      m_tvalid;
  logic                                      m_tready;
  logic [`RM_DATA_BITS-1:0]                  m_tdata;
  logic [KEEP_BITS-1:0]                      m_tkeep;
  logic                                      m_tlast;
  logic [ID_BITS-1:0]                        m_tid;
  logic                                      rpt_valid;
  logic [ID_BITS-1:0]                        rpt_tid;
  logic [TAG_BITS-1:0]                       rpt_tag;
  logic [LEN_BITS-1:0]                       rpt_count;
  logic                                      rpt_len_err;
  logic [`RM_DATA_BITS-1:0]                  rpt_sum;

  tb_beat_t         src_q [N_REG][$];  // beats each region still has to offer
  tb_beat_t         exp_q [N_IDS][$];  // expected output beats in order per tid
  pkt_report_t      rpt_q [N_IDS][$];  // expected report of every packet per tid
  logic [N_REG-1:0] taken;             // set at the edge a region beat was accepted
  int unsigned      wait_cnt [N_REG];  // other-region beats accepted while r waits
  int unsigned      total_beats = 0;
  int unsigned      total_pkts  = 0;
  int unsigned      out_count   = 0;
  int unsigned      rpt_seen    = 0;
  int unsigned      cycles      = 0;
  int unsigned      limit       = 0;
  int unsigned      beat_errs   = 0;
  int unsigned      rpt_errs    = 0;
  int unsigned      other_errs  = 0;
  logic             first_done;        // first accepted beat already checked

  region_merge_top u_dut (
    .aclk, .aresetn,
    .s_tvalid, .s_tready, .s_tdata, .s_tkeep, .s_tlast, .s_tid,
    .m_tvalid, .m_tready, .m_tdata, .m_tkeep, .m_tlast, .m_tid,
    .rpt_valid, .rpt_tid, .rpt_tag, .rpt_count, .rpt_len_err, .rpt_sum
  );

  always #20 aclk = ~aclk;  // 40 ns period

  // ------------------------------
  // stimulus and model
  // ------------------------------
  task automatic build_packets();
    beat_u       w;
    tb_beat_t    b;
    pkt_report_t rep;
    int unsigned len;
    int unsigned n_pay;
    for (int r = 0; r < N_REG; r++) begin
      for (int p = 0; p < PKTS; p++) begin
        len   = $urandom % (MAX_LEN + 1);
        n_pay = len;
        // roughly one packet in eight carries the wrong number of payload beats
        if ($urandom % 8 == 0) n_pay = (len == 0 || $urandom % 2 == 1) ? len + 1 : len - 1;
        // each region closes with a header alone whose len is the region index
        if (p == PKTS - 1) begin
          len   = r;
          n_pay = 0;
        end
        w.hdr.len   = LEN_BITS'(len);
        w.hdr.tag   = TAG_BITS'($urandom);
        b.word      = w;
        b.keep      = KEEP_BITS'($urandom);
        b.last      = (n_pay == 0);  // header-only packet
        b.tid       = ID_BITS'(r);
        src_q[r].push_back(b);
        exp_q[r].push_back(b);
        rep.tid     = ID_BITS'(r);
        rep.tag     = w.hdr.tag;
        rep.count   = LEN_BITS'(n_pay);
        rep.len_err = (n_pay != len);
        rep.sum     = '0;
        for (int unsigned k = 0; k < n_pay; k++) begin
          w.data  = $urandom;
          rep.sum = rep.sum + w.data;  // wraps at the word width
          b.word  = w;
          b.keep  = KEEP_BITS'($urandom);
          b.last  = (k == n_pay - 1);
          src_q[r].push_back(b);
          exp_q[r].push_back(b);
        end
        rpt_q[r].push_back(rep);
        total_pkts  = total_pkts + 1;
        total_beats = total_beats + 1 + n_pay;
      end
    end
    limit = total_beats * 8 + 200;
  endtask

  // runs on the falling edge and leaves the beat of a waiting region in place
  task automatic drive_inputs();
    tb_beat_t head;
    for (int r = 0; r < N_REG; r++) begin
      if (!s_tvalid[r] || taken[r]) begin
        taken[r] = 1'b0;
        if (src_q[r].size() > 0 && $urandom % 4 != 0) begin
          head        = src_q[r][0];
          s_tvalid[r] = 1'b1;
          s_tdata[r]  = head.word.data;
          s_tkeep[r]  = head.keep;
          s_tlast[r]  = head.last;
          s_tid[r]    = head.tid;
        end else begin
          s_tvalid[r] = 1'b0;
        end
      end
    end
    m_tready = ($urandom % 4 != 0);  // random back-pressure
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_beat(input beat_u got_word, input logic [KEEP_BITS-1:0] got_keep,
                            input logic got_last, input logic [ID_BITS-1:0] got_tid,
                            input tb_beat_t exp);
    if (got_word.data !== exp.word.data) begin
      beat_errs++;
      $display("FAIL %0t m_tdata got %h expected %h", $time, got_word.data, exp.word.data);
    end
    if (got_keep !== exp.keep) begin
      beat_errs++;
      $display("FAIL %0t m_tkeep got %h expected %h", $time, got_keep, exp.keep);
    end
    if (got_last !== exp.last) begin
      beat_errs++;
      $display("FAIL %0t m_tlast got %b expected %b", $time, got_last, exp.last);
    end
    if (got_tid !== exp.tid) begin
      beat_errs++;
      $display("FAIL %0t m_tid got %0d expected %0d", $time, got_tid, exp.tid);
    end
  endtask

  task automatic check_report(input pkt_report_t got, input pkt_report_t exp);
    if (got.tid !== exp.tid) begin
      rpt_errs++;
      $display("FAIL %0t rpt_tid got %0d expected %0d", $time, got.tid, exp.tid);
    end
    if (got.tag !== exp.tag) begin
      rpt_errs++;
      $display("FAIL %0t rpt_tag got %h expected %h", $time, got.tag, exp.tag);
    end
    if (got.count !== exp.count) begin
      rpt_errs++;
      $display("FAIL %0t rpt_count got %0d expected %0d", $time, got.count, exp.count);
    end
    if (got.len_err !== exp.len_err) begin
      rpt_errs++;
      $display("FAIL %0t rpt_len_err got %b expected %b", $time, got.len_err, exp.len_err);
    end
    if (got.sum !== exp.sum) begin
      rpt_errs++;
      $display("FAIL %0t rpt_sum got %h expected %h", $time, got.sum, exp.sum);
    end
  endtask

  // ------------------------------
  // monitor on the rising edge
  // ------------------------------
  always @(posedge aclk) begin
    logic [N_REG-1:0] acc_mask;
    int               lowest;
    beat_u            got_word;
    pkt_report_t      got_rpt;
    cycles++;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles with %0d of %0d beats out", cycles, out_count,
               total_beats);
      $display("TB FAILED");
      $finish;
    end else if (aresetn) begin
      acc_mask = s_tvalid & s_tready;
      for (int r = 0; r < N_REG; r++) begin
        if (acc_mask[r]) begin
          taken[r] = 1'b1;  // driver may offer the next beat
          void'(src_q[r].pop_front());
        end
        // a waiting region may see at most N-1 foreign beats go by
        if (!s_tvalid[r] || acc_mask[r]) begin
          wait_cnt[r] = 0;
        end else if (acc_mask != '0) begin
          wait_cnt[r]++;
          if (wait_cnt[r] > N_REG - 1) begin
            other_errs++;
            $display("region %0d waited through %0d other beats at %0t", r, wait_cnt[r], $time);
          end
        end
      end
      if (!first_done && acc_mask != '0) begin
        first_done = 1'b1;
        lowest     = N_REG;
        for (int r = N_REG - 1; r >= 0; r--) if (s_tvalid[r]) lowest = r;
        if (!acc_mask[lowest]) begin
          other_errs++;
          $display("first accepted beat did not come from region %0d, the lowest valid", lowest);
        end
      end
      if (m_tvalid && m_tready) begin
        out_count++;
        got_word.data = m_tdata;
        if (exp_q[m_tid].size() == 0) begin
          other_errs++;
          $display("beat for tid %0d arrived with nothing expected at %0t", m_tid, $time);
        end else begin
          check_beat(got_word, m_tkeep, m_tlast, m_tid, exp_q[m_tid].pop_front());
        end
      end
      if (rpt_valid) begin
        rpt_seen++;
        got_rpt = '{tid: rpt_tid, tag: rpt_tag, count: rpt_count, len_err: rpt_len_err,
                    sum: rpt_sum};
        if (!(m_tvalid && m_tlast)) begin
          other_errs++;
          $display("report strobe at %0t without a last beat on the output", $time);
        end
        if (rpt_q[rpt_tid].size() == 0) begin
          other_errs++;
          $display("extra report for tid %0d at %0t", rpt_tid, $time);
        end else begin
          check_report(got_rpt, rpt_q[rpt_tid].pop_front());
        end
      end
    end
  end

  // nothing may be left over in the model once all beats are out
  task automatic final_checks();
    for (int r = 0; r < N_IDS; r++) begin
      if (exp_q[r].size() != 0 || rpt_q[r].size() != 0) begin
        other_errs++;
        $display("tid %0d still has %0d beats and %0d reports expected", r, exp_q[r].size(),
                 rpt_q[r].size());
      end
    end
    if (out_count != total_beats || rpt_seen != total_pkts) begin
      other_errs++;
      $display("saw %0d beats and %0d reports, sent %0d beats in %0d packets", out_count,
               rpt_seen, total_beats, total_pkts);
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    void'($urandom(32'h51a61393));
    aclk       = 1'b0;
    aresetn    = 1'b0;
    s_tvalid   = '0;
    s_tdata    = '0;
    s_tkeep    = '0;
    s_tlast    = '0;
    s_tid      = '0;
    m_tready   = 1'b0;
    taken      = '0;
    first_done = 1'b0;
    for (int r = 0; r < N_REG; r++) wait_cnt[r] = 0;
    build_packets();
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    if (m_tvalid !== 1'b0 || rpt_valid !== 1'b0 || s_tready !== '0) begin
      other_errs++;
      $display("m_tvalid, rpt_valid or s_tready was not low coming out of reset");
    end
    while (out_count < total_beats || rpt_seen < total_pkts) begin
      drive_inputs();
      @(negedge aclk);
    end
    s_tvalid = '0;
    m_tready = 1'b1;
    repeat (8) @(negedge aclk);  // room for any stray beat or report to show up
    final_checks();
    $display("beat errors %0d, report errors %0d, other errors %0d", beat_errs, rpt_errs,
             other_errs);
    if (beat_errs + rpt_errs + other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* region_merge.f */
+incdir+include
source/stream_pkg.sv
source/report_pkg.sv
source/beat_if.sv
source/rr_arbiter.sv
source/pkt_decode.sv
source/pkt_execute.sv
source/pkt_result.sv
source/region_merge_top.sv
bench/region_merge_tb.sv

/* Makefile */
# Verilator build and run of the region_merge testbench
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= region_merge_tb
FILELIST ?= region_merge.f
OBJDIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL) and run $(TOP), fails unless the pass line is printed"
	@echo "  clean  remove $(OBJDIR)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	@out="$$(./$(OBJDIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)
